/* design/isa_pkg.sv */
package isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [15:0] imm_t;

   // Major opcodes
   localparam opcode_t OP_SPECIAL = 6'h00;
   localparam opcode_t OP_ADDIU   = 6'h09;
   localparam opcode_t OP_ORI     = 6'h0d;
   localparam opcode_t OP_LUI     = 6'h0f;
   localparam opcode_t OP_LW      = 6'h23;
   localparam opcode_t OP_SW      = 6'h2b;

   // SPECIAL funct codes
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_SLT  = 6'h2a;

   // Field positions within the instruction word
   localparam int unsigned OPCODE_LSB = 26;
   localparam int unsigned RS_LSB     = 21;
   localparam int unsigned RT_LSB     = 16;
   localparam int unsigned RD_LSB     = 11;
   localparam int unsigned FUNCT_LSB  = 0;
   localparam int unsigned IMM_LSB    = 0;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;
   import isa_pkg::*;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
   } alu_op_e;

   typedef enum logic [1:0] {SRC_REG, SRC_SEXT, SRC_ZEXT} src_b_e;

   typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM} fwd_sel_e;

   // All enables low means bubble
   typedef struct packed {
      alu_op_e   alu_op;
      src_b_e    src_b;
      logic      rs_re;
      logic      rt_re;
      logic      reg_we;
      reg_addr_t dest;
      logic      mem_read;
      logic      mem_write;
   } dec_ctrl_t;

   typedef struct packed {
      dec_ctrl_t ctrl;
      word_t     op_a;
      word_t     op_b;
      imm_t      imm;
      reg_addr_t rs;
      reg_addr_t rt;
   } ex_reg_t;

   typedef struct packed {
      word_t     result;
      word_t     wdata;
      reg_addr_t dest;
      logic      we;
      logic      mem_read;
      logic      mem_write;
   } mem_reg_t;

   typedef struct packed {
      word_t     data;
      reg_addr_t dest;
      logic      we;
   } wb_reg_t;

endpackage

/* design/decoder.sv */
`timescale 1ns/1ns
module decoder import isa_pkg::*, pipe_pkg::*; (
   input  word_t     instr_i,
   output dec_ctrl_t ctrl_o,
   output reg_addr_t rs_o,
   output reg_addr_t rt_o,
   output imm_t      imm_o
);
   opcode_t   opcode;
   funct_t    funct;
   reg_addr_t rd;
   logic      r_valid;
   alu_op_e   r_op;

   assign opcode = instr_i[OPCODE_LSB +: $bits(opcode_t)];
   assign funct  = instr_i[FUNCT_LSB +: $bits(funct_t)];
   assign rs_o   = instr_i[RS_LSB +: $bits(reg_addr_t)];
   assign rt_o   = instr_i[RT_LSB +: $bits(reg_addr_t)];
   assign rd     = instr_i[RD_LSB +: $bits(reg_addr_t)];
   assign imm_o  = instr_i[IMM_LSB +: $bits(imm_t)];

   // Register-register ops
   always_comb begin
      r_valid = 1'b1;
      r_op    = ALU_ADD;
      case (funct)
         FN_ADDU: r_op = ALU_ADD;
         FN_SUBU: r_op = ALU_SUB;
         FN_AND:  r_op = ALU_AND;
         FN_OR:   r_op = ALU_OR;
         FN_XOR:  r_op = ALU_XOR;
         FN_SLT:  r_op = ALU_SLT;
         default: r_valid = 1'b0;
      endcase
   end

   always_comb begin
      ctrl_o = '0;
      case (opcode)
         OP_SPECIAL: begin
            if (r_valid) begin
               ctrl_o.alu_op = r_op;
               ctrl_o.rs_re  = 1'b1;
               ctrl_o.rt_re  = 1'b1;
               ctrl_o.reg_we = 1'b1;
               ctrl_o.dest   = rd;
            end
         end
         OP_ADDIU, OP_LW: begin
            ctrl_o.src_b    = SRC_SEXT;
            ctrl_o.rs_re    = 1'b1;
            ctrl_o.reg_we   = 1'b1;
            ctrl_o.dest     = rt_o;
            ctrl_o.mem_read = (opcode == OP_LW);
         end
         OP_ORI, OP_LUI: begin
            ctrl_o.alu_op = (opcode == OP_LUI) ? ALU_LUI : ALU_OR;
            ctrl_o.src_b  = SRC_ZEXT;
            ctrl_o.rs_re  = (opcode == OP_ORI);
            ctrl_o.reg_we = 1'b1;
            ctrl_o.dest   = rt_o;
         end
         OP_SW: begin
            ctrl_o.src_b     = SRC_SEXT;
            ctrl_o.rs_re     = 1'b1;
            ctrl_o.rt_re     = 1'b1;
            ctrl_o.mem_write = 1'b1;
         end
         default: ctrl_o = '0;
      endcase
   end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ns
module reg_file import isa_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  reg_addr_t raddr_a_i,
   input  reg_addr_t raddr_b_i,
   output word_t     rdata_a_o,
   output word_t     rdata_b_o,
   input  logic      we_i,
   input  reg_addr_t waddr_i,
   input  word_t     wdata_i,
   input  reg_addr_t dbg_addr_i,
   output word_t     dbg_data_o
);
   word_t regs [32];

   // Write-through so writeback is visible to decode in the same cycle
   function automatic word_t read_port(reg_addr_t addr);
      word_t value;
      if (addr == '0) begin
         value = '0;
      end else if (we_i && addr == waddr_i) begin
         value = wdata_i;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   always_comb begin
      rdata_a_o  = read_port(raddr_a_i);
      rdata_b_o  = read_port(raddr_b_i);
      dbg_data_o = read_port(dbg_addr_i);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && waddr_i != '0) begin
         regs[waddr_i] <= wdata_i;
      end
   end

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ns
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
   input  ex_reg_t   ex_i,
   input  mem_reg_t  mem_i,
   input  reg_addr_t dec_rs_i,
   input  reg_addr_t dec_rt_i,
   input  dec_ctrl_t dec_ctrl_i,
   output fwd_sel_e  fwd_a_o,
   output fwd_sel_e  fwd_b_o,
   output logic      stall_o
);
   logic load_rs, load_rt;

   // Newest producer wins
   function automatic fwd_sel_e pick(reg_addr_t src, ex_reg_t ex, mem_reg_t mem);
      fwd_sel_e sel;
      if (src == '0) begin
         sel = FWD_RF;
      end else if (ex.ctrl.reg_we && ex.ctrl.dest == src) begin
         sel = FWD_EX;
      end else if (mem.we && mem.dest == src) begin
         sel = FWD_MEM;
      end else begin
         sel = FWD_RF;
      end
      return sel;
   endfunction

   assign fwd_a_o = pick(dec_rs_i, ex_i, mem_i);
   assign fwd_b_o = pick(dec_rt_i, ex_i, mem_i);

   // Load data only exists once the load reaches memory stage
   assign load_rs = dec_ctrl_i.rs_re && dec_rs_i == ex_i.ctrl.dest;
   assign load_rt = dec_ctrl_i.rt_re && dec_rt_i == ex_i.ctrl.dest;
   assign stall_o = ex_i.ctrl.mem_read && ex_i.ctrl.dest != '0 && (load_rs || load_rt);

endmodule

/* design/alu.sv */
`timescale 1ns/1ns
module alu import isa_pkg::*, pipe_pkg::*; (
   input  alu_op_e op_i,
   input  word_t   a_i,
   input  word_t   b_i,
   output word_t   result_o
);
   logic less;

   assign less = $signed(a_i) < $signed(b_i);

   always_comb begin
      case (op_i)
         ALU_ADD: begin
            result_o = a_i + b_i;
         end
         ALU_SUB: begin
            result_o = a_i - b_i;
         end
         ALU_AND: begin
            result_o = a_i & b_i;
         end
         ALU_OR: begin
            result_o = a_i | b_i;
         end
         ALU_XOR: begin
            result_o = a_i ^ b_i;
         end
         ALU_SLT: begin
            result_o = {31'b0, less};
         end
         // Immediate arrives zero-extended in the low half
         ALU_LUI: begin
            result_o = {b_i[15:0], 16'h0000};
         end
         default: begin
            result_o = '0;
         end
      endcase
   end

endmodule

/* design/pipe_core.sv */
`timescale 1ns/1ns
module pipe_core import isa_pkg::*, pipe_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   input  word_t      stop_pc_i,
   output logic       drained_o,
   input  reg_addr_t  dbg_addr_i,
   output word_t      dbg_data_o,
   output word_t      inst_addr_o,
   input  word_t      inst_data_i,
   output logic       data_en_o,
   output logic [3:0] data_wen_o,
   output word_t      data_addr_o,
   output word_t      data_wdata_o,
   input  word_t      data_rdata_i
);
   word_t     pc, id_instr;
   ex_reg_t   ex_q;
   mem_reg_t  mem_q;
   wb_reg_t   wb_q;
   logic      fetch_en, stall;
   dec_ctrl_t dec_ctrl;
   reg_addr_t dec_rs, dec_rt;
   imm_t      dec_imm;
   word_t     rf_a, rf_b, op_a, op_b;
   fwd_sel_e  fwd_a, fwd_b;
   word_t     alu_b, ex_result, mem_result;

   // Fetch
   assign fetch_en    = run_i && pc != stop_pc_i;
   assign inst_addr_o = pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= '0;
         id_instr <= '0;
      end else if (!stall) begin
         if (fetch_en) begin
            pc       <= pc + 32'd4;
            id_instr <= inst_data_i;
         end else begin
            id_instr <= '0;
         end
      end
   end

   // Decode
   decoder u_decoder (
      .instr_i (id_instr),
      .ctrl_o  (dec_ctrl),
      .rs_o    (dec_rs),
      .rt_o    (dec_rt),
      .imm_o   (dec_imm)
   );

   reg_file u_reg_file (
      .clk        (clk),
      .rst        (rst),
      .raddr_a_i  (dec_rs),
      .raddr_b_i  (dec_rt),
      .rdata_a_o  (rf_a),
      .rdata_b_o  (rf_b),
      .we_i       (wb_q.we),
      .waddr_i    (wb_q.dest),
      .wdata_i    (wb_q.data),
      .dbg_addr_i (dbg_addr_i),
      .dbg_data_o (dbg_data_o)
   );

   hazard_unit u_hazard_unit (
      .ex_i       (ex_q),
      .mem_i      (mem_q),
      .dec_rs_i   (dec_rs),
      .dec_rt_i   (dec_rt),
      .dec_ctrl_i (dec_ctrl),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b),
      .stall_o    (stall)
   );

   always_comb begin
      case (fwd_a)
         FWD_EX:  op_a = ex_result;
         FWD_MEM: op_a = mem_result;
         default: op_a = rf_a;
      endcase
      case (fwd_b)
         FWD_EX:  op_b = ex_result;
         FWD_MEM: op_b = mem_result;
         default: op_b = rf_b;
      endcase
   end

   // A stall turns the decode slot into a bubble
   always_ff @(posedge clk) begin
      ex_q.op_a <= op_a;
      ex_q.op_b <= op_b;
      ex_q.imm  <= dec_imm;
      ex_q.rs   <= dec_rs;
      ex_q.rt   <= dec_rt;
      if (rst || stall) begin
         ex_q.ctrl <= '0;
      end else begin
         ex_q.ctrl <= dec_ctrl;
      end
   end

   // Execute
   always_comb begin
      case (ex_q.ctrl.src_b)
         SRC_SEXT: alu_b = {{16{ex_q.imm[15]}}, ex_q.imm};
         SRC_ZEXT: alu_b = {16'h0000, ex_q.imm};
         default:  alu_b = ex_q.op_b;
      endcase
   end

   alu u_alu (
      .op_i     (ex_q.ctrl.alu_op),
      .a_i      (ex_q.op_a),
      .b_i      (alu_b),
      .result_o (ex_result)
   );

   always_ff @(posedge clk) begin
      mem_q.result <= ex_result;
      mem_q.wdata  <= ex_q.op_b;
      mem_q.dest   <= ex_q.ctrl.dest;
      if (rst) begin
         mem_q.we        <= 1'b0;
         mem_q.mem_read  <= 1'b0;
         mem_q.mem_write <= 1'b0;
      end else begin
         mem_q.we        <= ex_q.ctrl.reg_we;
         mem_q.mem_read  <= ex_q.ctrl.mem_read;
         mem_q.mem_write <= ex_q.ctrl.mem_write;
      end
   end

   // Memory, full-word accesses only
   assign data_en_o    = mem_q.mem_read || mem_q.mem_write;
   assign data_wen_o   = {4{mem_q.mem_write}};
   assign data_addr_o  = mem_q.result;
   assign data_wdata_o = mem_q.wdata;
   assign mem_result   = mem_q.mem_read ? data_rdata_i : mem_q.result;

   always_ff @(posedge clk) begin
      wb_q.data <= mem_result;
      wb_q.dest <= mem_q.dest;
      if (rst) begin
         wb_q.we <= 1'b0;
      end else begin
         wb_q.we <= mem_q.we;
      end
   end

   assign drained_o = pc == stop_pc_i
                      && !(dec_ctrl.reg_we || dec_ctrl.mem_read || dec_ctrl.mem_write)
                      && !(ex_q.ctrl.reg_we || ex_q.ctrl.mem_read || ex_q.ctrl.mem_write)
                      && !(mem_q.we || mem_q.mem_read || mem_q.mem_write)
                      && !wb_q.we;

endmodule

/* design/cfg_regs.sv */
`timescale 1ns/1ns
module cfg_regs import isa_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       psel_i,
   input  logic       penable_i,
   input  logic       pwrite_i,
   input  logic [7:0] paddr_i,
   input  word_t      pwdata_i,
   output word_t      prdata_o,
   output logic       pready_o,
   output logic       pslverr_o,
   output logic       run_o,
   output word_t      stop_pc_o,
   input  logic       drained_i,
   output reg_addr_t  dbg_addr_o,
   input  word_t      dbg_data_i
);
   localparam logic [7:0] ADDR_CTRL    = 8'h00;
   localparam logic [7:0] ADDR_STOP_PC = 8'h04;
   localparam logic [7:0] ADDR_STATUS  = 8'h08;

   logic  access;
   word_t rd_mux;

   assign access     = psel_i && penable_i;
   assign dbg_addr_o = paddr_i[6:2];
   assign pready_o   = 1'b1;
   assign pslverr_o  = 1'b0;

   always_ff @(posedge clk) begin
      if (rst) begin
         run_o     <= 1'b0;
         // Unreachable stop point until software sets one
         stop_pc_o <= 32'hffff_fffc;
      end else if (access && pwrite_i) begin
         if (paddr_i == ADDR_CTRL) begin
            run_o <= pwdata_i[0];
         end
         if (paddr_i == ADDR_STOP_PC) begin
            stop_pc_o <= pwdata_i;
         end
      end
   end

   // Upper half of the map is the general register window
   always_comb begin
      if (paddr_i[7]) begin
         rd_mux = dbg_data_i;
      end else begin
         case (paddr_i)
            ADDR_CTRL:    rd_mux = {31'b0, run_o};
            ADDR_STOP_PC: rd_mux = stop_pc_o;
            ADDR_STATUS:  rd_mux = {31'b0, drained_i};
            default:      rd_mux = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (access && !pwrite_i) begin
         prdata_o <= rd_mux;
      end
   end

endmodule

/* design/mips_top.sv */
`timescale 1ns/1ns
module mips_top import isa_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   output word_t      inst_addr_o,
   input  word_t      inst_data_i,
   output logic       data_en_o,
   output logic [3:0] data_wen_o,
   output word_t      data_addr_o,
   output word_t      data_wdata_o,
   input  word_t      data_rdata_i,
   input  logic       psel_i,
   input  logic       penable_i,
   input  logic       pwrite_i,
   input  logic [7:0] paddr_i,
   input  word_t      pwdata_i,
   output word_t      prdata_o,
   output logic       pready_o,
   output logic       pslverr_o
);
   logic      run, drained;
   word_t     stop_pc, dbg_data;
   reg_addr_t dbg_addr;

   pipe_core u_pipe_core (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run),
      .stop_pc_i    (stop_pc),
      .drained_o    (drained),
      .dbg_addr_i   (dbg_addr),
      .dbg_data_o   (dbg_data),
      .inst_addr_o  (inst_addr_o),
      .inst_data_i  (inst_data_i),
      .data_en_o    (data_en_o),
      .data_wen_o   (data_wen_o),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .data_rdata_i (data_rdata_i)
   );

   cfg_regs u_cfg_regs (
      .clk        (clk),
      .rst        (rst),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .run_o      (run),
      .stop_pc_o  (stop_pc),
      .drained_i  (drained),
      .dbg_addr_o (dbg_addr),
      .dbg_data_i (dbg_data)
   );

endmodule

/* bench/core_chk.sv */
`timescale 1ns/1ns
module core_chk (
   input logic       clk,
   input logic       rst,
   input logic       data_en_i,
   input logic [3:0] data_wen_i,
   input logic       psel_i,
   input logic       penable_i,
   input logic       pready_i
);

   // Byte strobes only inside an enabled access
   wen_needs_en: assert property (@(posedge clk) disable iff (rst)
      data_wen_i != 4'b0000 |-> data_en_i)
      else $error("data_wen_o active while data_en_o is low");

   ready_in_access: assert property (@(posedge clk) disable iff (rst)
      psel_i && penable_i |-> pready_i)
      else $error("pready_o low during an APB access phase");

   // Stage flags are cleared by the first reset edge
   idle_in_reset: assert property (@(posedge clk)
      rst && $past(rst) |-> !data_en_i)
      else $error("data_en_o high while reset is held");

endmodule

bind mips_top core_chk u_core_chk (
   .clk        (clk),
   .rst        (rst),
   .data_en_i  (data_en_o),
   .data_wen_i (data_wen_o),
   .psel_i     (psel_i),
   .penable_i  (penable_i),
   .pready_i   (pready_o)
);

/* bench/tb_top.sv */
`timescale 1ns/1ns
module tb_top import isa_pkg::*; ();
   localparam logic [7:0] CTRL_ADDR    = 8'h00;
   localparam logic [7:0] STOP_PC_ADDR = 8'h04;
   localparam logic [7:0] STATUS_ADDR  = 8'h08;
   localparam logic [7:0] GPR_BASE     = 8'h80;
   localparam int         APB_LIMIT    = 8;
   localparam int         DRAIN_LIMIT  = 50;

   logic       clk = 1'b0;
   logic       rst;
   word_t      inst_addr, inst_data;
   logic       data_en;
   logic [3:0] data_wen;
   word_t      data_addr, data_wdata, data_rdata;
   logic       psel, penable, pwrite;
   logic [7:0] paddr;
   word_t      pwdata, prdata;
   logic       pready, pslverr;

   word_t imem [64];
   word_t dmem [256];
   word_t cases [128];
   int    n_prog, n_store, n_reg;
   int    stores_seen = 0;

   always #5 clk = ~clk;

   mips_top DUT (
      .clk          (clk),
      .rst          (rst),
      .inst_addr_o  (inst_addr),
      .inst_data_i  (inst_data),
      .data_en_o    (data_en),
      .data_wen_o   (data_wen),
      .data_addr_o  (data_addr),
      .data_wdata_o (data_wdata),
      .data_rdata_i (data_rdata),
      .psel_i       (psel),
      .penable_i    (penable),
      .pwrite_i     (pwrite),
      .paddr_i      (paddr),
      .pwdata_i     (pwdata),
      .prdata_o     (prdata),
      .pready_o     (pready),
      .pslverr_o    (pslverr)
   );

   // Both memories answer in the same cycle
   assign inst_data  = imem[inst_addr[7:2]];
   assign data_rdata = dmem[data_addr[9:2]];

   function automatic word_t case_word(input int pos);
      return cases[7'(pos)];
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic idle_gap();
      repeat ($urandom_range(0, 3)) @(negedge clk);
   endtask

   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input word_t wdata, output word_t rdata);
      logic ready;
      logic err;
      int   cycles;
      ready  = 1'b0;
      err    = 1'b0;
      cycles = 0;
      idle_gap();
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      while (!ready) begin
         if (cycles == APB_LIMIT) begin
            abort_run("APB access phase never saw pready");
         end else begin
            @(posedge clk);
            ready  = pready;
            err    = pslverr;
            cycles = cycles + 1;
         end
      end
      check_value("pslverr_o", '0, {31'b0, err});
      @(negedge clk);
      rdata   = prdata;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input word_t data);
      word_t unused;
      apb_transfer(1'b1, addr, data, unused);
   endtask

   task automatic apb_read(input logic [7:0] addr, output word_t data);
      apb_transfer(1'b0, addr, '0, data);
   endtask

   task automatic wait_drained();
      word_t status;
      int    polls;
      status = '0;
      polls  = 0;
      while (!status[0]) begin
         if (polls == DRAIN_LIMIT) begin
            abort_run("Pipeline did not report drained in time");
         end else begin
            apb_read(STATUS_ADDR, status);
            polls = polls + 1;
         end
      end
   endtask

   task automatic check_reg(input int idx, input word_t expected);
      word_t value;
      apb_read(GPR_BASE + 8'(idx * 4), value);
      check_value($sformatf("gpr[%0d]", idx), expected, value);
   endtask

   // Stores must match the case list in order
   always @(negedge clk) begin
      int base;
      base = 4 + n_prog + 2 * stores_seen;
      if (!rst && data_wen != 4'b0000) begin
         if (stores_seen >= n_store) begin
            abort_run("A store appeared after the last expected store");
         end else begin
            check_value("data_en_o", 32'h1, {31'b0, data_en});
            check_value("data_wen_o", 32'hf, {28'b0, data_wen});
            check_value("data_addr_o", case_word(base), data_addr);
            check_value("data_wdata_o", case_word(base + 1), data_wdata);
            dmem[data_addr[9:2]] = data_wdata;
            stores_seen = stores_seen + 1;
         end
      end
   end

   initial begin
      word_t held_pc;
      int    reg_base;
      void'($urandom(32'hdd56));
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      for (int i = 0; i < 64; i++) begin
         imem[6'(i)] = '0;
      end
      // Unwritten data reads back its own byte address
      for (int i = 0; i < 256; i++) begin
         dmem[8'(i)] = 32'hc0de_0000 + word_t'(i * 4);
      end
      for (int i = 0; i < 128; i++) begin
         cases[7'(i)] = '0;
      end
      $readmemh("bench/program_cases.txt", cases);
      n_prog   = int'(case_word(0));
      n_store  = int'(case_word(2));
      n_reg    = int'(case_word(3));
      reg_base = 4 + n_prog + 2 * n_store;
      for (int i = 0; i < n_prog; i++) begin
         imem[6'(i)] = case_word(4 + i);
      end
      repeat (2) @(negedge clk);
      rst = 1'b0;

      // Idle core after reset
      check_value("data_en_o", '0, {31'b0, data_en});
      apb_write(STOP_PC_ADDR, '0);
      wait_drained();
      for (int i = 0; i < 32; i++) begin
         check_reg(i, '0);
      end

      // Program run up to the stop address
      apb_write(STOP_PC_ADDR, case_word(1));
      apb_write(CTRL_ADDR, 32'h1);
      wait_drained();
      check_value("store count", word_t'(n_store), word_t'(stores_seen));
      for (int i = 0; i < n_reg; i++) begin
         check_reg(int'(case_word(reg_base + 2 * i)), case_word(reg_base + 2 * i + 1));
      end

      // Let the PC run on through no-ops, then clear run
      apb_write(STOP_PC_ADDR, 32'hffff_fffc);
      apb_write(CTRL_ADDR, '0);
      held_pc = inst_addr;
      check_value("pc past stop address", 32'h1, {31'b0, held_pc > case_word(1)});
      repeat (6) begin
         @(negedge clk);
         check_value("inst_addr_o", held_pc, inst_addr);
      end
      check_reg(0, '0);

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* bench/program_cases.txt */
// Header: program word count, stop address, store count, register check count
// Then program words, expected stores as address data, final registers as index value
0000000e 00000038 00000003 0000000b
// Program from address 0
3c011234 34215678 2402fffd 00221821
00612023 0080282a ac030010 8c060010
00c13826 8c080020 01014824 00220025
ac090014 ac050018
// Stores in program order
00000010 12345675 00000014 00140020 00000018 00000001
// Final registers
00000000 00000000 00000001 12345678 00000002 fffffffd 00000003 12345675
00000004 fffffffd 00000005 00000001 00000006 12345675 00000007 0000000d
00000008 c0de0020 00000009 00140020 0000000a 00000000

/* all.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/alu.sv
design/pipe_core.sv
design/cfg_regs.sv
design/mips_top.sv
bench/core_chk.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_top -Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
